/* build.f */
+incdir+source
source/rv_isa_pkg.sv
source/pipe_pkg.sv
source/issue_if.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/alu_core.sv
tests/tb_clock_gen.sv
tests/tb_alu_core.sv

/* Makefile */
# Verilator build, run, lint and clean for the alu_core testbench

VERILATOR ?= verilator
TOP       ?= tb_alu_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the binary exits non-zero when the testbench stops with $fatal
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_alu_core.sv */
// alu_core testbench: encoders, reference function, stimulus, result compare and timeout
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module tb_alu_core;

    localparam logic [6:0]  OPC_OP         = 7'b0110011;
    localparam logic [6:0]  OPC_IMM        = 7'b0010011;
    localparam logic [6:0]  OPC_LUI        = 7'b0110111;
    localparam int unsigned RESET_CYCLES   = 16;
    localparam int unsigned RANDOM_COUNT   = 300;
    localparam int unsigned DIRECTED_COUNT = 30;
    localparam int unsigned TIMEOUT_CYCLES =
        RESET_CYCLES + 2 * (RANDOM_COUNT + DIRECTED_COUNT) + 50;

    typedef struct packed {
        logic [31:0]           due; // cycle of the result strobe
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      data;
    } expect_t;

    logic                  clk;
    logic                  reset;
    logic                  inst_valid;
    logic [`XLEN-1:0]      inst;
    logic                  result_valid;
    logic [`REG_IDX_W-1:0] result_rd;
    logic [`XLEN-1:0]      result_data;

    logic [`XLEN-1:0] model_regs [`REG_COUNT];
    expect_t          exp_q [$];
    expect_t          head;
    int unsigned      cycle = 0;

    tb_clock_gen #(.PERIOD_NS(4.0)) u_clock (.clk(clk));

    alu_core DUT (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data)
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped in cycle %0d", cycle);
    endtask

    function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] imm_op(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_IMM};
    endfunction

    function automatic logic [31:0] lui_op(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // architectural result of one instruction against the model register file
    function automatic logic expected_result(
        input  logic [`XLEN-1:0]      ins,
        output logic [`REG_IDX_W-1:0] rd,
        output logic [`XLEN-1:0]      data
    );
        logic [`XLEN-1:0]        a;
        logic [`XLEN-1:0]        b;
        logic signed [`XLEN-1:0] sra_val;
        logic                    is_op;
        a     = model_regs[ins[19:15]];
        is_op = (ins[6:0] == OPC_OP);
        rd    = ins[11:7];
        data  = '0;
        if (ins[6:0] == OPC_LUI)
        begin
            data = {ins[31:12], 12'h000};
            return 1'b1;
        end
        if (!is_op && ins[6:0] != OPC_IMM)
            return 1'b0; // loads, stores, branches give nothing
        b       = is_op ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        sra_val = $signed(a) >>> b[4:0];
        case (ins[14:12])
            3'd0: data = (is_op && ins[30]) ? a - b : a + b; // no subi in the isa
            3'd1: data = a << b[4:0];
            3'd2: data = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            3'd3: data = {{(`XLEN-1){1'b0}}, a < b};
            3'd4: data = a ^ b;
            3'd5: data = ins[30] ? sra_val : a >> b[4:0];
            3'd6: data = a | b;
            default: data = a & b;
        endcase
        return 1'b1;
    endfunction

    // any supported instruction, registers kept low so results get reused
    function automatic logic [31:0] random_inst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        rd  = 5'($urandom_range(0, 15));
        rs1 = 5'($urandom_range(0, 15));
        rs2 = 5'($urandom_range(0, 15));
        imm = 12'($urandom);
        case ($urandom_range(0, 19))
            0:  return reg_op(7'h00, rs2, rs1, 3'd0, rd); // add
            1:  return reg_op(7'h20, rs2, rs1, 3'd0, rd); // sub
            2:  return reg_op(7'h00, rs2, rs1, 3'd1, rd);
            3:  return reg_op(7'h00, rs2, rs1, 3'd2, rd);
            4:  return reg_op(7'h00, rs2, rs1, 3'd3, rd);
            5:  return reg_op(7'h00, rs2, rs1, 3'd4, rd);
            6:  return reg_op(7'h00, rs2, rs1, 3'd5, rd); // srl
            7:  return reg_op(7'h20, rs2, rs1, 3'd5, rd); // sra
            8:  return reg_op(7'h00, rs2, rs1, 3'd6, rd);
            9:  return reg_op(7'h00, rs2, rs1, 3'd7, rd);
            10: return imm_op(imm, rs1, 3'd0, rd);
            11: return imm_op(imm, rs1, 3'd2, rd);
            12: return imm_op(imm, rs1, 3'd3, rd);
            13: return imm_op(imm, rs1, 3'd4, rd);
            14: return imm_op(imm, rs1, 3'd6, rd);
            15: return imm_op(imm, rs1, 3'd7, rd);
            16: return imm_op({7'h00, imm[4:0]}, rs1, 3'd1, rd); // slli
            17: return imm_op({7'h00, imm[4:0]}, rs1, 3'd5, rd); // srli
            18: return imm_op({7'h20, imm[4:0]}, rs1, 3'd5, rd); // srai
            default: return lui_op(20'($urandom), rd);
        endcase
    endfunction

    // one strobe cycle, expectation queued with its due cycle
    task automatic send(input logic [`XLEN-1:0] ins);
        logic                  has_result;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      data;
        expect_t               e;
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= ins;
        has_result = expected_result(ins, rd, data);
        if (has_result)
        begin
            e.due  = cycle + 1 + `PIPE_LATENCY;
            e.rd   = rd;
            e.data = data;
            exp_q.push_back(e);
            if (rd != '0)
                model_regs[rd] = data; // x0 stays zero
        end
    endtask

    task automatic idle(input int unsigned n);
        repeat (n)
        begin
            @(posedge clk);
            inst_valid <= 1'b0;
        end
    endtask

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        assert (cycle < TIMEOUT_CYCLES)
        else stop_with_error($sformatf("timeout after %0d cycles, results did not drain",
                                       cycle));
    end

    // result strobe against the head of the queue
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (result_valid)
            begin
                assert (exp_q.size() != 0 && exp_q[0].due == cycle)
                else stop_with_error($sformatf("unexpected result strobe in cycle %0d", cycle));
                head = exp_q.pop_front();
                assert (result_rd == head.rd)
                else stop_with_error($sformatf("** Error: result_rd = 0x%h, expected 0x%h",
                                               result_rd, head.rd));
                assert (result_data == head.data)
                else stop_with_error($sformatf("** Error: result_data = 0x%h, expected 0x%h",
                                               result_data, head.data));
            end
            else
            begin
                assert (exp_q.size() == 0 || exp_q[0].due != cycle)
                else stop_with_error($sformatf("missing result strobe, one was due in cycle %0d",
                                               cycle));
            end
        end
    end

    initial
    begin
        logic [`REG_IDX_W-1:0] p1;
        logic [`REG_IDX_W-1:0] p2;
        logic [`REG_IDX_W-1:0] rd;
        logic [6:0]            f7;
        logic [2:0]            f3;
        void'($urandom(32'h6d98));
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        for (int i = 0; i < `REG_COUNT; i++)
            model_regs[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // back-to-back chain, rs1 one older and rs2 two older
        send(imm_op(12'h123, 5'd0, 3'd0, 5'd1));
        send(imm_op(12'hfb3, 5'd0, 3'd0, 5'd2));
        p2 = 5'd1;
        p1 = 5'd2;
        for (int k = 0; k < 12; k++)
        begin
            rd = 5'(3 + k % 5);
            f7 = (k % 3 == 1) ? 7'h20 : 7'h00; // sub
            f3 = (k % 3 == 2) ? 3'd4 : 3'd0;   // xor
            send(reg_op(f7, p2, p1, f3, rd));
            p2 = p1;
            p1 = rd;
        end
        idle(2);

        send(imm_op(12'h055, 5'd0, 3'd0, 5'd0));     // addi x0 still reports its value
        send(reg_op(7'h00, 5'd0, 5'd0, 3'd0, 5'd8)); // x0 reads back as zero
        idle(2);

        // load, store and branch aimed at x10 must leave it alone
        send(imm_op(12'h02a, 5'd0, 3'd0, 5'd10));
        send({12'h004, 5'd0, 3'b010, 5'd10, 7'b0000011});
        send({7'h00, 5'd10, 5'd0, 3'b010, 5'd10, 7'b0100011});
        send({7'h00, 5'd0, 5'd0, 3'b000, 5'd10, 7'b1100011});
        send(reg_op(7'h00, 5'd0, 5'd10, 3'd0, 5'd11));
        idle(2);

        // signed boundary compares
        send(lui_op(20'h80000, 5'd12));                 // most negative
        send(lui_op(20'h80000, 5'd13));
        send(imm_op(12'hfff, 5'd13, 3'd0, 5'd13));      // most positive
        send(reg_op(7'h00, 5'd13, 5'd12, 3'd2, 5'd14));
        send(reg_op(7'h00, 5'd13, 5'd12, 3'd3, 5'd15));
        send(reg_op(7'h00, 5'd12, 5'd13, 3'd2, 5'd14));
        send(reg_op(7'h00, 5'd12, 5'd13, 3'd3, 5'd15));
        send(imm_op(12'hfff, 5'd12, 3'd2, 5'd16));      // slti against -1
        send(imm_op(12'hfff, 5'd13, 3'd3, 5'd17));      // sltiu against all ones
        idle(2);

        for (int i = 0; i < RANDOM_COUNT; i++)
        begin
            send(random_inst());
            idle($urandom_range(0, 2));
        end

        while (exp_q.size() != 0)
            idle(1);
        idle(8); // quiet cycles to catch a stray strobe
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
// free-running testbench clock generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);
    initial
        clk = 1'b0;

    always
        #(PERIOD_NS / 2.0) clk = ~clk; // 50 percent duty cycle

endmodule

`default_nettype wire

/* source/alu_core.sv */
// top level joining decode, execute and result stages over the issue interface
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module alu_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inst_valid,
    input  logic [`XLEN-1:0]      inst,
    output logic                  result_valid,
    output logic [`REG_IDX_W-1:0] result_rd,
    output logic [`XLEN-1:0]      result_data
);
    import pipe_pkg::*;

    ex_result_t            ex_q;
    logic                  e_fwd_valid;
    logic [`REG_IDX_W-1:0] e_fwd_rd;
    logic [`XLEN-1:0]      e_fwd_data;

    issue_if issue_bus ();

    // register file written from the result mux, same edge as the write-back register
    decode_stage u_decode (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb_valid   (e_fwd_valid),
        .wb_rd      (e_fwd_rd),
        .wb_data    (e_fwd_data),
        .issue      (issue_bus.decode)
    );

    execute_stage u_execute (
        .clk         (clk),
        .reset       (reset),
        .issue       (issue_bus.execute),
        .e_fwd_valid (e_fwd_valid),
        .e_fwd_rd    (e_fwd_rd),
        .e_fwd_data  (e_fwd_data),
        .wb_valid    (result_valid), // older forwarding source
        .wb_rd       (result_rd),
        .wb_data     (result_data),
        .ex_q        (ex_q)
    );

    result_stage u_result (
        .clk         (clk),
        .reset       (reset),
        .ex_q        (ex_q),
        .e_fwd_valid (e_fwd_valid),
        .e_fwd_rd    (e_fwd_rd),
        .e_fwd_data  (e_fwd_data),
        .wb_valid    (result_valid),
        .wb_rd       (result_rd),
        .wb_data     (result_data)
    );

endmodule

`default_nettype wire

/* source/result_stage.sv */
// result stage: result multiplexer, forwarding source and write-back register
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module result_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  pipe_pkg::ex_result_t  ex_q,
    output logic                  e_fwd_valid,
    output logic [`REG_IDX_W-1:0] e_fwd_rd,
    output logic [`XLEN-1:0]      e_fwd_data,
    output logic                  wb_valid,
    output logic [`REG_IDX_W-1:0] wb_rd,
    output logic [`XLEN-1:0]      wb_data
);
    import pipe_pkg::*;

    logic [`XLEN-1:0] sel_data;

    always_comb
    begin
        case (ex_q.result_sel)
            res_alu:  sel_data = ex_q.alu_out;
            res_cmp:  sel_data = {{(`XLEN-1){1'b0}}, ex_q.cmp_flag};
            res_uimm: sel_data = ex_q.u_imm;
            default:  sel_data = ex_q.alu_out;
        endcase
    end

    // youngest forwarding source for execute
    assign e_fwd_valid = ex_q.valid;
    assign e_fwd_rd    = ex_q.rd;
    assign e_fwd_data  = sel_data;

    always_ff @(posedge clk)
    begin
        wb_rd   <= ex_q.rd;
        wb_data <= sel_data;
        if (reset)
            wb_valid <= 1'b0;
        else
            wb_valid <= ex_q.valid;
    end

    result_sel_legal: assert property (@(posedge clk) disable iff (reset)
        ex_q.valid |-> ex_q.result_sel inside {res_alu, res_cmp, res_uimm});

endmodule

`default_nettype wire

/* source/execute_stage.sv */
// execute stage with operand forwarding, ALU, less-than compare and execute register
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module execute_stage (
    input  logic                  clk,
    input  logic                  reset,
    issue_if.execute              issue,
    input  logic                  e_fwd_valid,
    input  logic [`REG_IDX_W-1:0] e_fwd_rd,
    input  logic [`XLEN-1:0]      e_fwd_data,
    input  logic                  wb_valid,
    input  logic [`REG_IDX_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]      wb_data,
    output pipe_pkg::ex_result_t  ex_q
);
    import rv_isa_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_res;
    logic             less;

    // result stage is one older, so it wins over write-back
    function automatic logic [`XLEN-1:0] fwd_pick(
        input logic [`REG_IDX_W-1:0] rs,
        input logic [`XLEN-1:0]      rf_val
    );
        if (e_fwd_valid && e_fwd_rd != '0 && e_fwd_rd == rs)
            return e_fwd_data;
        else if (wb_valid && wb_rd != '0 && wb_rd == rs)
            return wb_data;
        else
            return rf_val;
    endfunction

    always_comb
    begin
        op_a    = fwd_pick(issue.rs1, issue.op_a);
        rs2_val = fwd_pick(issue.rs2, issue.op_b);
    end

    assign op_b    = issue.use_imm ? issue.imm : rs2_val;
    assign shamt   = op_b[4:0];

    always_comb
    begin
        case (issue.alu_op)
            alu_add: alu_res = issue.alt ? op_a - op_b : op_a + op_b;
            alu_sll: alu_res = op_a << shamt;
            alu_xor: alu_res = op_a ^ op_b;
            alu_srl:
            begin
                if (issue.alt)
                    alu_res = $signed(op_a) >>> shamt; // sra
                else
                    alu_res = op_a >> shamt;
            end
            alu_or:  alu_res = op_a | op_b;
            alu_and: alu_res = op_a & op_b;
            default: alu_res = op_a + op_b;
        endcase
    end

    assign less = (issue.cmp_op == cmp_ltu) ? (op_a < op_b)
                                            : ($signed(op_a) < $signed(op_b));

    always_ff @(posedge clk)
    begin
        ex_q.rd         <= issue.rd;
        ex_q.result_sel <= issue.result_sel;
        ex_q.alu_out    <= alu_res;
        ex_q.cmp_flag   <= less;
        ex_q.u_imm      <= issue.u_imm;
        if (reset)
            ex_q.valid <= 1'b0;
        else
            ex_q.valid <= issue.valid;
    end

    ex_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(ex_q.valid));

endmodule

`default_nettype wire

/* source/decode_stage.sv */
// decode stage: register file, field decode, immediates and issue register
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inst_valid,
    input  logic [`XLEN-1:0]      inst,
    input  logic                  wb_valid,
    input  logic [`REG_IDX_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]      wb_data,
    issue_if.decode               issue
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic [`XLEN-1:0]      regs [`REG_COUNT];
    opcode_t               opcode;
    logic [2:0]            funct3;
    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    logic                  supported;
    logic                  use_imm;
    logic                  alt;
    alu_op_t               alu_op;
    result_sel_t           result_sel;

    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // x0 never written, so it stays at its reset value of zero
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wb_valid && wb_rd != '0)
            regs[wb_rd] <= wb_data;
    end

    always_comb
    begin
        supported  = 1'b1;
        use_imm    = 1'b0;
        alt        = 1'b0;
        alu_op     = alu_op_t'(funct3);
        result_sel = res_alu;
        case (opcode)
            op_reg: alt = inst[30] && (funct3 == F3_ADD || funct3 == F3_SRL);
            op_imm:
            begin
                use_imm = 1'b1;
                alt     = inst[30] && funct3 == F3_SRL; // srai only, no subi
            end
            op_lui: result_sel = res_uimm;
            default: supported = 1'b0; // loads, stores, branches etc
        endcase
        // slt family goes through the compare, keep the alu on a legal op
        if (opcode != op_lui && (funct3 == F3_SLT || funct3 == F3_SLTU))
        begin
            result_sel = res_cmp;
            alu_op     = alu_add;
        end
    end

    // issue register, only valid carries a reset
    always_ff @(posedge clk)
    begin
        issue.rd         <= inst[11:7];
        issue.rs1        <= rs1;
        issue.rs2        <= rs2;
        issue.op_a       <= (rs1 == '0) ? '0 : regs[rs1];
        issue.op_b       <= (rs2 == '0) ? '0 : regs[rs2];
        issue.imm        <= {{(`XLEN-12){inst[31]}}, inst[31:20]}; // I-type
        issue.use_imm    <= use_imm;
        issue.alu_op     <= alu_op;
        issue.alt        <= alt;
        issue.cmp_op     <= cmp_op_t'(funct3[0]);
        issue.result_sel <= result_sel;
        issue.u_imm      <= {inst[31:12], 12'h000};
        if (reset)
            issue.valid <= 1'b0;
        else
            issue.valid <= inst_valid && supported;
    end

    wb_rd_known: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> !$isunknown(wb_rd));

endmodule

`default_nettype wire

/* source/issue_if.sv */
// decode to execute issue interface with decode and execute modports
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

interface issue_if;
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic                  valid; // strobe, other fields only meaningful with it
    logic [`REG_IDX_W-1:0] rd;
    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    logic [`XLEN-1:0]      op_a; // register file values read at decode
    logic [`XLEN-1:0]      op_b;
    logic [`XLEN-1:0]      imm;
    logic                  use_imm;
    alu_op_t               alu_op;
    logic                  alt; // sub / sra
    cmp_op_t               cmp_op;
    result_sel_t           result_sel;
    logic [`XLEN-1:0]      u_imm;

    modport decode (output valid, rd, rs1, rs2, op_a, op_b, imm, use_imm,
                    alu_op, alt, cmp_op, result_sel, u_imm);
    modport execute (input valid, rd, rs1, rs2, op_a, op_b, imm, use_imm,
                     alu_op, alt, cmp_op, result_sel, u_imm);
endinterface

`default_nettype wire

/* source/pipe_pkg.sv */
// pipeline types: result select encoding and execute register contents
`default_nettype none

`include "core_defs.svh"

package pipe_pkg;

    // which value the result stage writes back
    typedef enum logic [1:0] {
        res_alu  = 2'd0, // alu output
        res_cmp  = 2'd1, // less-than flag, zero extended
        res_uimm = 2'd2  // upper immediate for lui
    } result_sel_t;

    // everything execute hands to the result stage
    typedef struct packed {
        logic                  valid;
        logic [`REG_IDX_W-1:0] rd;
        result_sel_t           result_sel;
        logic [`XLEN-1:0]      alu_out;
        logic                  cmp_flag;
        logic [`XLEN-1:0]      u_imm;
    } ex_result_t;

endpackage

`default_nettype wire

/* source/rv_isa_pkg.sv */
// instruction set types: major opcodes, funct3 codes, ALU and compare operations
`default_nettype none

package rv_isa_pkg;

    // major opcodes handled by the core, everything else is dropped
    typedef enum logic [6:0] {
        op_reg = 7'b0110011, // register-register ALU
        op_imm = 7'b0010011, // register-immediate ALU
        op_lui = 7'b0110111
    } opcode_t;

    // funct3 values that need special handling at decode
    localparam logic [2:0] F3_ADD  = 3'b000; // add / sub
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_SRL  = 3'b101; // srl / sra

    // coded like funct3 so decode can pass the field through
    // sub and sra come from the separate alt bit
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

    // matches funct3[0] of slt / sltu
    typedef enum logic {
        cmp_lt  = 1'b0,
        cmp_ltu = 1'b1
    } cmp_op_t;

endpackage

`default_nettype wire

/* source/core_defs.svh */
// data width, register file size, register index width and pipeline latency macros
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data path and instruction width
`define XLEN 32

// architectural registers x0..x31
`define REG_COUNT 32

// bits needed to name one register
`define REG_IDX_W 5

// strobe in cycle n, result strobe in cycle n+3
// decode, execute and result stage each add one register
`define PIPE_LATENCY 3

`endif
